/* verilog.f */
source/udp_src_pkg.sv
source/lock_sync.sv
source/packet_pacer.sv
source/payload_framer.sv
source/echo_fifo.sv
source/source_select.sv
source/udp_test_source.sv
testbench/tb_udp_test_source.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it
# pass or fail comes from the pass line in the output

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_udp_test_source -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -Fqx "PASS: all tests" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* testbench/tb_udp_test_source.sv */
`default_nettype none

module tb_udp_test_source;

  timeunit 1ns;
  timeprecision 100ps;

  import udp_src_pkg::*;

  localparam int unsigned PKT_INTERVAL = 64;
  localparam int unsigned ECHO_DEPTH   = 16;
  localparam logic [31:0] SEED         = 32'h69c7_0b33;

  // packet targets per phase
  localparam int GEN_PKTS_PLAIN  = 3;
  localparam int GEN_PKTS_BP     = 8;
  localparam int GEN_PKTS_MIX    = 12;
  localparam int ECHO_PKTS       = 10;
  localparam int TOTAL_PKTS      = GEN_PKTS_MIX + 2 * ECHO_PKTS;
  localparam int WATCHDOG_CYCLES = TOTAL_PKTS * PKT_INTERVAL * 4;

  // dut inputs
  logic       sys_clk_100MHz;
  logic       tx_axis_aresetn;
  logic       mmcm_locked;
  logic       gen_sel;
  axis_data_t echo_in_data;
  axis_keep_t echo_in_keep;
  logic       echo_in_valid;
  logic       echo_in_last;
  logic       tx_ready;

  // dut outputs
  wire             udp_enable;
  wire             sfp_tx_disable;
  wire             echo_in_ready;
  wire axis_data_t tx_data;
  wire axis_keep_t tx_keep;
  wire             tx_valid;
  wire             tx_last;

  // stimulus control
  logic        rand_ready;
  logic        rand_sel;
  logic        sel_hold;
  logic [31:0] pace_rng;
  logic [31:0] echo_rng;
  int          echo_sent;
  string       test_name;
  int          data_errors;
  int          protocol_errors;

  // reference model state
  axis_data_t exp_echo_data [1024];
  axis_keep_t exp_echo_keep [1024];
  logic       exp_echo_last [1024];
  logic [9:0] echo_wr;
  logic [9:0] echo_rd;
  int         beat_pos;
  logic       kind_gen;
  pkt_seq_t   exp_seq;
  axis_data_t exp_seq_text;
  int         gen_pkts;
  int         echo_pkts;

  // expected beat, combinational from model state
  logic       tx_fire;
  logic       cur_is_gen;
  axis_data_t exp_data;
  axis_keep_t exp_keep;
  logic       exp_last;

  udp_test_source #(
    .PKT_INTERVAL (PKT_INTERVAL),
    .ECHO_DEPTH   (ECHO_DEPTH)
  ) dut_i (
    .sys_clk_100MHz  (sys_clk_100MHz),
    .tx_axis_aresetn (tx_axis_aresetn),
    .mmcm_locked     (mmcm_locked),
    .gen_sel         (gen_sel),
    .echo_in_data    (echo_in_data),
    .echo_in_keep    (echo_in_keep),
    .echo_in_valid   (echo_in_valid),
    .echo_in_last    (echo_in_last),
    .tx_ready        (tx_ready),
    .udp_enable      (udp_enable),
    .sfp_tx_disable  (sfp_tx_disable),
    .echo_in_ready   (echo_in_ready),
    .tx_data         (tx_data),
    .tx_keep         (tx_keep),
    .tx_valid        (tx_valid),
    .tx_last         (tx_last)
  );

  always #5 sys_clk_100MHz = ~sys_clk_100MHz;

  // numerical recipes constants
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // printf the number, then place char i in byte i
  function automatic axis_data_t hex_text(input pkt_seq_t seq);
    string      s;
    axis_data_t text;
    s = $sformatf("%08x", seq);
    for (int i = 0; i < 8; i++) begin
      text[8 * i +: 8] = s[i];
    end
    return text;
  endfunction

  // ==========================================================
  // reference model
  // ==========================================================
  always_comb begin
    tx_fire    = tx_valid && tx_ready;
    // a packet is classified by its first beat
    cur_is_gen = (beat_pos == 0) ? (tx_data == GREETING_0) : kind_gen;
    exp_data   = '0;
    exp_keep   = KEEP_ALL;
    exp_last   = 1'b1;
    if (cur_is_gen) begin
      case (beat_pos)
        0:       exp_data = GREETING_0;
        1:       exp_data = GREETING_1;
        2:       exp_data = GREETING_2;
        3:       exp_data = exp_seq_text;
        default: exp_data = '0;
      endcase
      exp_last = (beat_pos == BEATS_PER_PKT - 1);
    end else begin
      exp_data = exp_echo_data[echo_rd];
      exp_keep = exp_echo_keep[echo_rd];
      exp_last = exp_echo_last[echo_rd];
    end
  end

  always @(posedge sys_clk_100MHz or negedge tx_axis_aresetn) begin
    if (!tx_axis_aresetn) begin
      echo_wr      <= '0;
      echo_rd      <= '0;
      beat_pos     <= 0;
      kind_gen     <= 1'b0;
      exp_seq      <= '0;
      exp_seq_text <= hex_text('0);
      gen_pkts     <= 0;
      echo_pkts    <= 0;
    end else begin
      // every accepted echo beat joins the expected queue
      if (echo_in_valid && echo_in_ready) begin
        exp_echo_data[echo_wr] <= echo_in_data;
        exp_echo_keep[echo_wr] <= echo_in_keep;
        exp_echo_last[echo_wr] <= echo_in_last;
        echo_wr                <= echo_wr + 1'b1;
      end
      if (tx_fire) begin
        if (beat_pos == 0) begin
          kind_gen <= cur_is_gen;
        end
        if (!cur_is_gen) begin
          echo_rd <= echo_rd + 1'b1;
        end
        if (tx_last) begin
          beat_pos <= 0;
          if (cur_is_gen) begin
            exp_seq      <= exp_seq + 1;
            exp_seq_text <= hex_text(exp_seq + 1);
            gen_pkts     <= gen_pkts + 1;
          end else begin
            echo_pkts <= echo_pkts + 1;
          end
        end else begin
          beat_pos <= beat_pos + 1;
        end
      end
    end
  end

  // ==========================================================
  // assertions
  // ==========================================================
  // nothing leaves the dut before lock
  reset_state: assert property (@(posedge sys_clk_100MHz)
    !mmcm_locked |-> (!tx_valid && !udp_enable && sfp_tx_disable))
    else begin
      protocol_errors++;
      $display("%s: outputs not in reset state before lock", test_name);
    end

  lock_enable: assert property (@(posedge sys_clk_100MHz) disable iff (!tx_axis_aresetn)
    $past(mmcm_locked, 2) |-> udp_enable)
    else begin
      protocol_errors++;
      $display("%s: udp_enable still low two cycles after lock", test_name);
    end

  lock_early: assert property (@(posedge sys_clk_100MHz) disable iff (!tx_axis_aresetn)
    $rose(udp_enable) |-> $past(mmcm_locked, 2))
    else begin
      protocol_errors++;
      $display("%s: udp_enable rose too early after lock", test_name);
    end

  laser_off: assert property (@(posedge sys_clk_100MHz) disable iff (!tx_axis_aresetn)
    sfp_tx_disable == !$past(udp_enable))
    else begin
      protocol_errors++;
      $display("%s: sfp_tx_disable does not follow udp_enable by one cycle", test_name);
    end

  data_match: assert property (@(posedge sys_clk_100MHz) disable iff (!tx_axis_aresetn)
    tx_fire |-> (tx_data == exp_data))
    else begin
      data_errors++;
      $display("FAILED %s tx_data: expected %h actual %h",
               test_name, $sampled(exp_data), $sampled(tx_data));
    end

  keep_match: assert property (@(posedge sys_clk_100MHz) disable iff (!tx_axis_aresetn)
    tx_fire |-> (tx_keep == exp_keep))
    else begin
      data_errors++;
      $display("FAILED %s tx_keep: expected %h actual %h",
               test_name, $sampled(exp_keep), $sampled(tx_keep));
    end

  last_match: assert property (@(posedge sys_clk_100MHz) disable iff (!tx_axis_aresetn)
    tx_fire |-> (tx_last == exp_last))
    else begin
      data_errors++;
      $display("FAILED %s tx_last: expected %b actual %b",
               test_name, $sampled(exp_last), $sampled(tx_last));
    end

  echo_known: assert property (@(posedge sys_clk_100MHz) disable iff (!tx_axis_aresetn)
    (tx_fire && !cur_is_gen) |-> (echo_wr != echo_rd))
    else begin
      protocol_errors++;
      $display("%s: tx beat is neither greeting nor a pending echo beat", test_name);
    end

  // stalled beat must hold still
  stall_hold: assert property (@(posedge sys_clk_100MHz) disable iff (!tx_axis_aresetn)
    (tx_valid && !tx_ready) |=>
      (tx_valid && $stable(tx_data) && $stable(tx_keep) && $stable(tx_last)))
    else begin
      protocol_errors++;
      $display("%s: tx beat changed or dropped while stalled", test_name);
    end

  // ==========================================================
  // stimulus
  // ==========================================================
  // tx_ready and gen_sel, 1 ns after each edge
  always begin
    @(posedge sys_clk_100MHz);
    #1;
    if (rand_ready) begin
      pace_rng = lcg_next(pace_rng);
      tx_ready = (pace_rng[31:30] != 2'b00);
    end else begin
      tx_ready = 1'b1;
    end
    if (rand_sel) begin
      pace_rng = lcg_next(pace_rng);
      if (pace_rng[31:28] == 4'h0) begin
        gen_sel = ~gen_sel;
      end
    end else begin
      gen_sel = sel_hold;
    end
  end

  // one echo packet of 1 to 6 random beats
  task automatic send_echo_pkt();
    int len;
    @(posedge sys_clk_100MHz);
    #1;
    echo_rng = lcg_next(echo_rng);
    len      = 1 + int'(echo_rng[31:16] % 16'd6);
    for (int b = 0; b < len; b++) begin
      echo_rng            = lcg_next(echo_rng);
      echo_in_data[63:32] = echo_rng;
      echo_rng            = lcg_next(echo_rng);
      echo_in_data[31:0]  = echo_rng;
      echo_in_keep        = echo_rng[23:16];
      echo_in_last        = (b == len - 1);
      echo_in_valid       = 1'b1;
      do begin
        @(posedge sys_clk_100MHz);
      end while (!echo_in_ready);
      #1;
    end
    echo_in_valid = 1'b0;
    echo_in_last  = 1'b0;
    echo_sent++;
  endtask

  task automatic send_echo_burst(input int count);
    for (int p = 0; p < count; p++) begin
      send_echo_pkt();
    end
  endtask

  task automatic wait_gen_pkts(input int count);
    while (gen_pkts < count) begin
      @(posedge sys_clk_100MHz);
    end
  endtask

  // all echo beats out and no packet open
  task automatic wait_drained();
    @(posedge sys_clk_100MHz);
    while (echo_wr != echo_rd || beat_pos != 0) begin
      @(posedge sys_clk_100MHz);
    end
  endtask

  task automatic print_counts();
    $display("errors: data %0d, protocol %0d, gen packets %0d, echo packets %0d",
             data_errors, protocol_errors, gen_pkts, echo_pkts);
  endtask

  // ==========================================================
  // test sequence
  // ==========================================================
  initial begin
    sys_clk_100MHz  = 1'b0;
    tx_axis_aresetn = 1'b1;
    mmcm_locked     = 1'b0;
    gen_sel         = 1'b1;
    echo_in_data    = '0;
    echo_in_keep    = '0;
    echo_in_valid   = 1'b0;
    echo_in_last    = 1'b0;
    tx_ready        = 1'b1;
    rand_ready      = 1'b0;
    rand_sel        = 1'b0;
    sel_hold        = 1'b1;
    pace_rng        = SEED;
    echo_rng        = lcg_next(lcg_next(lcg_next(SEED)));
    echo_sent       = 0;
    data_errors     = 0;
    protocol_errors = 0;
    test_name       = "reset";

    // reset falls just after time zero
    #1 tx_axis_aresetn = 1'b0;
    repeat (8) @(posedge sys_clk_100MHz);
    #1 tx_axis_aresetn = 1'b1;
    // a few idle cycles out of reset, still unlocked
    repeat (4) @(posedge sys_clk_100MHz);
    test_name = "lock";
    #1 mmcm_locked = 1'b1;

    test_name = "gen_format";
    wait_gen_pkts(GEN_PKTS_PLAIN);

    test_name  = "back_pressure";
    rand_ready = 1'b1;
    wait_gen_pkts(GEN_PKTS_BP);

    // generator held back while echo drains
    test_name = "echo";
    sel_hold  = 1'b0;
    send_echo_burst(ECHO_PKTS);
    wait_drained();

    test_name = "switching";
    rand_sel  = 1'b1;
    fork
      send_echo_burst(ECHO_PKTS);
      wait_gen_pkts(GEN_PKTS_MIX);
    join
    wait_drained();
    rand_sel   = 1'b0;
    rand_ready = 1'b0;
    sel_hold   = 1'b1;

    test_name = "final";
    assert (echo_pkts == echo_sent) else begin
      protocol_errors++;
      $display("%s: %0d echo packets sent but %0d came out", test_name, echo_sent, echo_pkts);
    end

    print_counts();
    if (data_errors == 0 && protocol_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge sys_clk_100MHz);
    $display("%s: run did not finish within %0d cycles", test_name, WATCHDOG_CYCLES);
    print_counts();
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* source/udp_test_source.sv */
`default_nettype none

module udp_test_source #(
  parameter int unsigned PKT_INTERVAL = 15_625_000,
  parameter int unsigned ECHO_DEPTH   = 16
) (
  input  wire                          sys_clk_100MHz,
  input  wire                          tx_axis_aresetn,
  input  wire                          mmcm_locked,
  input  wire                          gen_sel,
  input  wire udp_src_pkg::axis_data_t echo_in_data,
  input  wire udp_src_pkg::axis_keep_t echo_in_keep,
  input  wire                          echo_in_valid,
  input  wire                          echo_in_last,
  input  wire                          tx_ready,
  output wire                          udp_enable,
  output wire                          sfp_tx_disable,
  output wire                          echo_in_ready,
  output wire udp_src_pkg::axis_data_t tx_data,
  output wire udp_src_pkg::axis_keep_t tx_keep,
  output wire                          tx_valid,
  output wire                          tx_last
);

  import udp_src_pkg::*;

  // pacer to framer
  wire           req_valid;
  wire           req_ready;
  wire pkt_seq_t req_seq;

  // framer to selector
  wire axis_data_t gen_data;
  wire axis_keep_t gen_keep;
  wire             gen_valid;
  wire             gen_last;
  wire             gen_ready;

  // fifo to selector
  wire axis_data_t echo_data;
  wire axis_keep_t echo_keep;
  wire             echo_valid;
  wire             echo_last;
  wire             echo_ready;

  // ==========================================================
  // lock and enable
  // ==========================================================
  lock_sync lock_sync_i (
    .sys_clk_100MHz  (sys_clk_100MHz),
    .tx_axis_aresetn (tx_axis_aresetn),
    .mmcm_locked     (mmcm_locked),
    .udp_enable      (udp_enable),
    .sfp_tx_disable  (sfp_tx_disable)
  );

  // ==========================================================
  // generator path
  // ==========================================================
  packet_pacer #(
    .PKT_INTERVAL (PKT_INTERVAL)
  ) packet_pacer_i (
    .sys_clk_100MHz  (sys_clk_100MHz),
    .tx_axis_aresetn (tx_axis_aresetn),
    .udp_enable      (udp_enable),
    .req_ready       (req_ready),
    .req_valid       (req_valid),
    .req_seq         (req_seq)
  );

  payload_framer payload_framer_i (
    .sys_clk_100MHz  (sys_clk_100MHz),
    .tx_axis_aresetn (tx_axis_aresetn),
    .req_valid       (req_valid),
    .req_seq         (req_seq),
    .gen_ready       (gen_ready),
    .req_ready       (req_ready),
    .gen_data        (gen_data),
    .gen_keep        (gen_keep),
    .gen_valid       (gen_valid),
    .gen_last        (gen_last)
  );

  // echo path buffer
  echo_fifo #(
    .ECHO_DEPTH (ECHO_DEPTH)
  ) echo_fifo_i (
    .sys_clk_100MHz  (sys_clk_100MHz),
    .tx_axis_aresetn (tx_axis_aresetn),
    .echo_in_data    (echo_in_data),
    .echo_in_keep    (echo_in_keep),
    .echo_in_valid   (echo_in_valid),
    .echo_in_last    (echo_in_last),
    .echo_ready      (echo_ready),
    .echo_in_ready   (echo_in_ready),
    .echo_data       (echo_data),
    .echo_keep       (echo_keep),
    .echo_valid      (echo_valid),
    .echo_last       (echo_last)
  );

  // packet-boundary mux and output stage
  source_select source_select_i (
    .sys_clk_100MHz  (sys_clk_100MHz),
    .tx_axis_aresetn (tx_axis_aresetn),
    .gen_sel         (gen_sel),
    .gen_data        (gen_data),
    .gen_keep        (gen_keep),
    .gen_valid       (gen_valid),
    .gen_last        (gen_last),
    .echo_data       (echo_data),
    .echo_keep       (echo_keep),
    .echo_valid      (echo_valid),
    .echo_last       (echo_last),
    .tx_ready        (tx_ready),
    .gen_ready       (gen_ready),
    .echo_ready      (echo_ready),
    .tx_data         (tx_data),
    .tx_keep         (tx_keep),
    .tx_valid        (tx_valid),
    .tx_last         (tx_last)
  );

endmodule

`default_nettype wire

/* source/source_select.sv */
`default_nettype none

module source_select (
  input  wire                          sys_clk_100MHz,
  input  wire                          tx_axis_aresetn,
  input  wire                          gen_sel,
  input  wire udp_src_pkg::axis_data_t gen_data,
  input  wire udp_src_pkg::axis_keep_t gen_keep,
  input  wire                          gen_valid,
  input  wire                          gen_last,
  input  wire udp_src_pkg::axis_data_t echo_data,
  input  wire udp_src_pkg::axis_keep_t echo_keep,
  input  wire                          echo_valid,
  input  wire                          echo_last,
  input  wire                          tx_ready,
  output logic                         gen_ready,
  output logic                         echo_ready,
  output udp_src_pkg::axis_data_t      tx_data,
  output udp_src_pkg::axis_keep_t      tx_keep,
  output logic                         tx_valid,
  output logic                         tx_last
);

  import udp_src_pkg::*;

  logic       in_pkt_q;
  logic       sel_q;
  logic       cur_sel;
  logic       take;
  logic       src_valid;
  logic       src_last;
  logic       xfer;
  axis_data_t src_data;
  axis_keep_t src_keep;

  // selection frozen while a packet is open
  assign cur_sel = in_pkt_q ? sel_q : gen_sel;

  // output stage can take a beat
  assign take = !tx_valid || tx_ready;

  // losing side just waits, never drained
  assign gen_ready  = take && cur_sel;
  assign echo_ready = take && !cur_sel;

  // ==========================================================
  // source mux
  // ==========================================================
  assign src_valid = cur_sel ? gen_valid : echo_valid;
  assign src_last  = cur_sel ? gen_last  : echo_last;
  assign src_data  = cur_sel ? gen_data  : echo_data;
  assign src_keep  = cur_sel ? gen_keep  : echo_keep;
  assign xfer      = take && src_valid;

  // packet tracking
  always_ff @(posedge sys_clk_100MHz or negedge tx_axis_aresetn) begin
    if (!tx_axis_aresetn) begin
      in_pkt_q <= 1'b0;
      sel_q    <= 1'b1;
    end else if (xfer) begin
      // first beat opens, last beat closes
      in_pkt_q <= !src_last;
      sel_q    <= cur_sel;
    end
  end

  // output register, valid part
  always_ff @(posedge sys_clk_100MHz or negedge tx_axis_aresetn) begin
    if (!tx_axis_aresetn) begin
      tx_valid <= 1'b0;
    end else if (take) begin
      tx_valid <= src_valid;
    end
  end

  // output register, payload part
  always_ff @(posedge sys_clk_100MHz) begin
    if (xfer) begin
      tx_data <= src_data;
      tx_keep <= src_keep;
      tx_last <= src_last;
    end
  end

endmodule

`default_nettype wire

/* source/echo_fifo.sv */
`default_nettype none

module echo_fifo #(
  parameter int unsigned ECHO_DEPTH = 16
) (
  input  wire                          sys_clk_100MHz,
  input  wire                          tx_axis_aresetn,
  input  wire udp_src_pkg::axis_data_t echo_in_data,
  input  wire udp_src_pkg::axis_keep_t echo_in_keep,
  input  wire                          echo_in_valid,
  input  wire                          echo_in_last,
  input  wire                          echo_ready,
  output logic                         echo_in_ready,
  output udp_src_pkg::axis_data_t      echo_data,
  output udp_src_pkg::axis_keep_t      echo_keep,
  output logic                         echo_valid,
  output logic                         echo_last
);

  import udp_src_pkg::*;

  localparam int PTR_W = (ECHO_DEPTH > 1) ? $clog2(ECHO_DEPTH) : 1;

  // storage, no reset
  axis_data_t mem_data [ECHO_DEPTH];
  axis_keep_t mem_keep [ECHO_DEPTH];
  logic       mem_last [ECHO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  logic wr_en;
  logic load_out;
  logic bypass;
  logic push;
  logic pop;

  assign echo_in_ready = (count != (PTR_W + 1)'(ECHO_DEPTH));
  assign wr_en         = echo_in_valid && echo_in_ready;

  // output reg empty or being drained
  assign load_out = !echo_valid || echo_ready;
  // empty buffer, write goes straight to the output
  assign bypass   = load_out && (count == '0) && wr_en;
  assign pop      = load_out && (count != '0);
  assign push     = wr_en && !bypass;

  // ==========================================================
  // pointers and fill level
  // ==========================================================
  always_ff @(posedge sys_clk_100MHz or negedge tx_axis_aresetn) begin
    if (!tx_axis_aresetn) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      echo_valid <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
      if (load_out) begin
        echo_valid <= pop || bypass;
      end
    end
  end

  // write side
  always_ff @(posedge sys_clk_100MHz) begin
    if (push) begin
      mem_data[wr_ptr] <= echo_in_data;
      mem_keep[wr_ptr] <= echo_in_keep;
      mem_last[wr_ptr] <= echo_in_last;
    end
  end

  // registered head of queue
  always_ff @(posedge sys_clk_100MHz) begin
    if (pop) begin
      echo_data <= mem_data[rd_ptr];
      echo_keep <= mem_keep[rd_ptr];
      echo_last <= mem_last[rd_ptr];
    end else if (bypass) begin
      echo_data <= echo_in_data;
      echo_keep <= echo_in_keep;
      echo_last <= echo_in_last;
    end
  end

endmodule

`default_nettype wire

/* source/payload_framer.sv */
`default_nettype none

module payload_framer (
  input  wire                     sys_clk_100MHz,
  input  wire                     tx_axis_aresetn,
  input  wire                     req_valid,
  input  wire udp_src_pkg::pkt_seq_t req_seq,
  input  wire                     gen_ready,
  output logic                    req_ready,
  output udp_src_pkg::axis_data_t gen_data,
  output udp_src_pkg::axis_keep_t gen_keep,
  output logic                    gen_valid,
  output logic                    gen_last
);

  import udp_src_pkg::*;

  // ascii '0'
  localparam logic [7:0] HEX_DIGIT_0 = 8'h30;
  localparam beat_idx_t  LAST_BEAT   = beat_idx_t'(BEATS_PER_PKT - 1);

  framer_state_t state_q;
  beat_idx_t     beat_q;
  pkt_seq_t      seq_q;
  axis_data_t    seq_text;
  logic          gen_xfer;

  // seq number as 8 lower-case hex chars
  // most significant nibble lands in byte 0
  function automatic axis_data_t seq_to_hex(input pkt_seq_t seq);
    axis_data_t text;
    logic [3:0] nib;
    text = '0;
    for (int i = 0; i < 8; i++) begin
      nib = seq[4 * (7 - i) +: 4];
      if (nib < 4'd10) begin
        text[8 * i +: 8] = HEX_DIGIT_0 + {4'd0, nib};
      end else begin
        text[8 * i +: 8] = HEX_LOWER_A + {4'd0, nib} - 8'd10;
      end
    end
    return text;
  endfunction

  assign req_ready = (state_q == fr_idle);
  assign gen_valid = (state_q == fr_send);
  assign gen_last  = gen_valid && (beat_q == LAST_BEAT);
  assign gen_keep  = KEEP_ALL;
  assign gen_xfer  = gen_valid && gen_ready;
  assign seq_text  = seq_to_hex(seq_q);

  // beat payload select
  always_comb begin
    case (beat_q)
      2'd0:    gen_data = GREETING_0;
      2'd1:    gen_data = GREETING_1;
      2'd2:    gen_data = GREETING_2;
      default: gen_data = seq_text;
    endcase
  end

  // ==========================================================
  // fsm: idle until a request, then four beats
  // ==========================================================
  always_ff @(posedge sys_clk_100MHz or negedge tx_axis_aresetn) begin
    if (!tx_axis_aresetn) begin
      state_q <= fr_idle;
      beat_q  <= '0;
    end else begin
      case (state_q)
        fr_idle: begin
          if (req_valid) begin
            state_q <= fr_send;
            beat_q  <= '0;
          end
        end
        fr_send: begin
          if (gen_xfer) begin
            // back to idle right after the last beat
            if (beat_q == LAST_BEAT) begin
              state_q <= fr_idle;
            end
            beat_q <= beat_q + 1'b1;
          end
        end
        default: state_q <= fr_idle;
      endcase
    end
  end

  // seq latched on accept
  always_ff @(posedge sys_clk_100MHz) begin
    if (req_valid && req_ready) begin
      seq_q <= req_seq;
    end
  end

endmodule

`default_nettype wire

/* source/packet_pacer.sv */
`default_nettype none

module packet_pacer #(
  parameter int unsigned PKT_INTERVAL = 15_625_000
) (
  input  wire                   sys_clk_100MHz,
  input  wire                   tx_axis_aresetn,
  input  wire                   udp_enable,
  input  wire                   req_ready,
  output logic                  req_valid,
  output udp_src_pkg::pkt_seq_t req_seq
);

  import udp_src_pkg::*;

  // timer counts 0 .. PKT_INTERVAL-1
  localparam int TIMER_W = (PKT_INTERVAL > 1) ? $clog2(PKT_INTERVAL) : 1;

  logic [TIMER_W-1:0] timer_q;
  logic               expire;
  logic               accept;

  assign expire = udp_enable && (timer_q == TIMER_W'(PKT_INTERVAL - 1));
  assign accept = req_valid && req_ready;

  // ==========================================================
  // interval timer
  // ==========================================================
  always_ff @(posedge sys_clk_100MHz or negedge tx_axis_aresetn) begin
    if (!tx_axis_aresetn) begin
      timer_q <= '0;
    end else if (!udp_enable) begin
      // held at zero while link is down
      timer_q <= '0;
    end else if (expire) begin
      timer_q <= '0;
    end else begin
      timer_q <= timer_q + 1'b1;
    end
  end

  // ==========================================================
  // request flag and sequence counter
  // ==========================================================
  always_ff @(posedge sys_clk_100MHz or negedge tx_axis_aresetn) begin
    if (!tx_axis_aresetn) begin
      req_valid <= 1'b0;
      req_seq   <= '0;
    end else begin
      // number advances only on accept, skipped ticks leave no gap
      if (accept) begin
        req_seq <= req_seq + 1'b1;
      end
      // tick while still pending is dropped
      if (expire && (!req_valid || req_ready)) begin
        req_valid <= 1'b1;
      end else if (accept) begin
        req_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* source/lock_sync.sv */
`default_nettype none

module lock_sync (
  input  wire  sys_clk_100MHz,
  input  wire  tx_axis_aresetn,
  input  wire  mmcm_locked,
  output logic udp_enable,
  output logic sfp_tx_disable
);

  // two-stage synchronizer for the async lock
  logic [1:0] lock_q;

  always_ff @(posedge sys_clk_100MHz or negedge tx_axis_aresetn) begin
    if (!tx_axis_aresetn) begin
      lock_q <= 2'b00;
    end else begin
      lock_q <= {lock_q[0], mmcm_locked};
    end
  end

  // enable follows the second stage
  assign udp_enable = lock_q[1];

  // optical tx kept off until lock has settled
  // one more stage, so the laser comes up after the enable
  always_ff @(posedge sys_clk_100MHz or negedge tx_axis_aresetn) begin
    if (!tx_axis_aresetn) begin
      sfp_tx_disable <= 1'b1;
    end else begin
      sfp_tx_disable <= ~lock_q[1];
    end
  end

endmodule

`default_nettype wire

/* source/udp_src_pkg.sv */
`default_nettype none

package udp_src_pkg;

  // ==========================================================
  // stream widths
  // ==========================================================
  typedef logic [63:0] axis_data_t;
  typedef logic [7:0]  axis_keep_t;

  // packet numbering and beat position
  typedef logic [31:0] pkt_seq_t;
  typedef logic [1:0]  beat_idx_t;

  // generator fsm
  typedef enum logic {
    fr_idle,
    fr_send
  } framer_state_t;

  // ==========================================================
  // packet shape
  // ==========================================================
  localparam int unsigned BEATS_PER_PKT = 4;
  localparam axis_keep_t  KEEP_ALL      = 8'hff;

  // greeting text, first character in byte 0
  // "Hello fr"
  localparam axis_data_t GREETING_0 = 64'h72_66_20_6f_6c_6c_65_48;
  // "om FPGA "
  localparam axis_data_t GREETING_1 = 64'h20_41_47_50_46_20_6d_6f;
  // "PKT no. "
  localparam axis_data_t GREETING_2 = 64'h20_2e_6f_6e_20_54_4b_50;

  // ascii 'a', base for hex digits above 9
  localparam logic [7:0] HEX_LOWER_A = 8'h61;

endpackage

`default_nettype wire
